// File: erx_pkg.sv
package erx_pkg;

   localparam logic [11:0] CHIP_ID      = 12'h999;    // Own page, dstaddr[31:20]
   localparam logic [31:0] BURST_STRIDE = 32'd8;      // Step between burst beats
   localparam int          MBOX_DEPTH   = 8;          // Mailbox entries
   localparam int          MBOX_AW      = $clog2(MBOX_DEPTH);
   localparam logic [19:0] MBOX_ADDR    = 20'hf0320;  // Mailbox offset in own page

   // Link packet, write bit at the low end
   typedef struct packed {
      logic [31:0] srcaddr;   // Return address for reads
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;     // 1 write, 0 read
   } emesh_packet_t;

   // Register index from dstaddr[5:2]
   typedef enum logic [3:0] {
      REG_RXCFG     = 4'd0,
      REG_RXSTATUS  = 4'd1,
      REG_RXOFFSET  = 4'd2,
      REG_RXIDELAY0 = 4'd3,
      REG_RXIDELAY1 = 4'd4,
      REG_RXMAILBOX = 4'd5
   } reg_addr_t;

   typedef enum logic [1:0] {
      REMAP_NONE    = 2'd0,
      REMAP_STATIC  = 2'd1,
      REMAP_DYNAMIC = 2'd2
   } remap_mode_t;

   // Values double as output register index
   typedef enum logic [1:0] {
      DEST_WR   = 2'd0,
      DEST_RD   = 2'd1,
      DEST_RR   = 2'd2,
      DEST_MBOX = 2'd3
   } dest_t;

   typedef struct packed {
      logic        cfg_en;    // Register file select
      logic        mbox_en;   // Mailbox select
      logic        we;
      reg_addr_t   addr;
      logic [31:0] din;
   } mi_bus_t;

   typedef struct packed {
      remap_mode_t mode;
      logic [11:0] sel;       // Bits of dstaddr[31:20] to replace
      logic [11:0] pattern;   // Replacement bits
      logic [31:0] base;      // Dynamic offset
   } remap_cfg_t;

endpackage

// File: erx_protocol.sv
`timescale 1ns/1ps

module erx_protocol (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   stall,       // Freeze from arbiter
   input  logic                   rx_access,   // Already qualified by waits
   input  logic                   rx_burst,
   input  erx_pkg::emesh_packet_t rx_packet,
   output logic                   out_access,
   output erx_pkg::emesh_packet_t out_packet
);

   logic [31:0]            last_dstaddr;  // Previous accepted address
   erx_pkg::emesh_packet_t pkt_next;

   always_comb begin
      pkt_next = rx_packet;
      if (rx_burst) begin
         pkt_next.dstaddr = last_dstaddr + erx_pkg::BURST_STRIDE;  // Burst continuation
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_access   <= 1'b0;
         out_packet   <= '0;
         last_dstaddr <= '0;
      end else if (!stall) begin
         out_access <= rx_access;
         out_packet <= pkt_next;
         if (rx_access) begin
            last_dstaddr <= pkt_next.dstaddr;
         end
      end
   end

   // Bursts only exist for write streams
   a_burst_write : assert property (@(posedge clk) disable iff (!rst_n)
      rx_access && rx_burst |-> rx_packet.write);

endmodule

// File: erx_remap.sv
`timescale 1ns/1ps

module erx_remap (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   stall,
   input  erx_pkg::remap_cfg_t    remap,
   input  logic                   in_access,
   input  erx_pkg::emesh_packet_t in_packet,
   output logic                   out_access,
   output erx_pkg::emesh_packet_t out_packet
);

   erx_pkg::emesh_packet_t pkt_next;
   logic [11:0]            page;        // Upper address bits

   assign page = in_packet.dstaddr[31:20];

   always_comb begin
      pkt_next = in_packet;
      case (remap.mode)
         erx_pkg::REMAP_STATIC: begin
            // Selected page bits come from pattern
            pkt_next.dstaddr[31:20] = (remap.pattern & remap.sel) | (page & ~remap.sel);
         end
         erx_pkg::REMAP_DYNAMIC: begin
            pkt_next.dstaddr = in_packet.dstaddr + remap.base;  // Offset add
         end
         default: begin
            pkt_next = in_packet;  // Pass as is
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_access <= 1'b0;
         out_packet <= '0;
      end else if (!stall) begin
         out_access <= in_access;
         out_packet <= pkt_next;
      end
   end

endmodule

// File: erx_cfg.sv
`timescale 1ns/1ps

module erx_cfg (
   input  logic                clk,
   input  logic                rst_n,
   input  erx_pkg::mi_bus_t    mi,
   output logic [31:0]         rdata,
   input  logic [4:0]          status_in,       // Wait levels
   input  logic                mbox_overflow,
   output logic                overflow_clr,    // Status read clears sticky bit
   output erx_pkg::remap_cfg_t remap,
   output logic                mailbox_irq_en,
   output logic [44:0]         idelay_value,
   output logic                load_taps
);

   logic [26:0] rxcfg;
   logic [31:0] rxoffset;
   logic [31:0] idelay0;
   logic [12:0] idelay1;    // Upper taps
   logic        cfg_wr;
   logic        tap_wr_q;   // IDELAY1 written last cycle

   assign cfg_wr = mi.cfg_en & mi.we;
   assign overflow_clr = mi.cfg_en & ~mi.we & (mi.addr == erx_pkg::REG_RXSTATUS);

   // RXCFG fields
   assign remap.mode     = erx_pkg::remap_mode_t'(rxcfg[1:0]);
   assign remap.sel      = rxcfg[13:2];
   assign remap.pattern  = rxcfg[25:14];
   assign remap.base     = rxoffset;
   assign mailbox_irq_en = rxcfg[26];
   assign idelay_value   = {idelay1, idelay0};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rxcfg     <= '0;
         rxoffset  <= '0;
         idelay0   <= '0;
         idelay1   <= '0;
         tap_wr_q  <= 1'b0;
         load_taps <= 1'b0;
      end else begin
         if (cfg_wr) begin
            case (mi.addr)
               erx_pkg::REG_RXCFG:     rxcfg    <= mi.din[26:0];
               erx_pkg::REG_RXOFFSET:  rxoffset <= mi.din;
               erx_pkg::REG_RXIDELAY0: idelay0  <= mi.din;
               erx_pkg::REG_RXIDELAY1: idelay1  <= mi.din[12:0];
               default: ;              // Read only or mailbox
            endcase
         end
         tap_wr_q  <= cfg_wr && (mi.addr == erx_pkg::REG_RXIDELAY1);
         load_taps <= tap_wr_q & ~load_taps;  // Back to back writes give one pulse
      end
   end

   // Combinational read mux
   always_comb begin
      case (mi.addr)
         erx_pkg::REG_RXCFG:     rdata = {5'b0, rxcfg};
         erx_pkg::REG_RXSTATUS:  rdata = {26'b0, mbox_overflow, status_in};
         erx_pkg::REG_RXOFFSET:  rdata = rxoffset;
         erx_pkg::REG_RXIDELAY0: rdata = idelay0;
         erx_pkg::REG_RXIDELAY1: rdata = {19'b0, idelay1};
         default:                rdata = '0;
      endcase
   end

   // Single strobe, two cycles after an IDELAY1 write
   a_load_taps_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      load_taps |-> $past(cfg_wr && (mi.addr == erx_pkg::REG_RXIDELAY1), 2) &&
                    !$past(load_taps));

endmodule

// File: erx_cfgif.sv
`timescale 1ns/1ps

module erx_cfgif (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   cfg_access_in,
   input  erx_pkg::emesh_packet_t cfg_packet_in,
   output erx_pkg::mi_bus_t       mi,
   input  logic [31:0]            cfg_rdata,
   input  logic [31:0]            mbox_rdata,
   output logic                   resp_access,
   output erx_pkg::emesh_packet_t resp_packet,
   input  logic                   resp_wait,     // Arbiter busy on rxrr
   output logic                   cfg_wait
);

   logic             take;       // Request for this chip accepted
   erx_pkg::reg_addr_t addr;

   assign cfg_wait = resp_access;  // One response in flight
   assign addr     = erx_pkg::reg_addr_t'(cfg_packet_in.dstaddr[5:2]);
   assign take     = cfg_access_in & ~cfg_wait &
                     (cfg_packet_in.dstaddr[31:20] == erx_pkg::CHIP_ID);

   always_comb begin
      mi.cfg_en  = take & (addr != erx_pkg::REG_RXMAILBOX);
      mi.mbox_en = take & (addr == erx_pkg::REG_RXMAILBOX);
      mi.we      = cfg_packet_in.write;
      mi.addr    = addr;
      mi.din     = cfg_packet_in.data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_access <= 1'b0;
         resp_packet <= '0;
      end else if (take && !cfg_packet_in.write) begin
         resp_access          <= 1'b1;
         resp_packet.write    <= 1'b1;                    // Response is a write back
         resp_packet.datamode <= cfg_packet_in.datamode;
         resp_packet.ctrlmode <= cfg_packet_in.ctrlmode;
         resp_packet.dstaddr  <= cfg_packet_in.srcaddr;   // Swap addresses
         resp_packet.srcaddr  <= cfg_packet_in.dstaddr;
         resp_packet.data     <= mi.mbox_en ? mbox_rdata : cfg_rdata;
      end else if (!resp_wait) begin
         resp_access <= 1'b0;  // Taken by arbiter
      end
   end

endmodule

// File: erx_mailbox.sv
`timescale 1ns/1ps

module erx_mailbox (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             mbox_access,   // Write strobe from arbiter
   input  logic [31:0]      mbox_data,
   input  erx_pkg::mi_bus_t mi,
   output logic [31:0]      rdata,
   input  logic             irq_en,
   output logic             overflow,      // Sticky
   input  logic             overflow_clr,
   output logic             mailbox_irq
);

   logic [31:0]                 fifo_mem [erx_pkg::MBOX_DEPTH];
   logic [erx_pkg::MBOX_AW-1:0] wr_ptr;
   logic [erx_pkg::MBOX_AW-1:0] rd_ptr;
   logic [erx_pkg::MBOX_AW:0]   count;
   logic                        push;
   logic                        pop;
   logic                        full;
   logic                        empty;

   assign full  = count == (erx_pkg::MBOX_AW + 1)'(erx_pkg::MBOX_DEPTH);
   assign empty = count == '0;
   assign push  = mbox_access & ~full;             // Dropped when full
   assign pop   = mi.mbox_en & ~mi.we & ~empty;    // Read pops head

   assign rdata       = empty ? 32'b0 : fifo_mem[rd_ptr];
   assign mailbox_irq = ~empty & irq_en;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= mbox_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (erx_pkg::MBOX_AW + 1)'(push) - (erx_pkg::MBOX_AW + 1)'(pop);
         if (mbox_access && full) begin
            overflow <= 1'b1;  // Set wins over clear
         end else if (overflow_clr) begin
            overflow <= 1'b0;
         end
      end
   end

endmodule

// File: erx_arbiter.sv
`timescale 1ns/1ps

module erx_arbiter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_access,
   input  erx_pkg::emesh_packet_t in_packet,
   input  logic                   cfg_access,    // Config read response
   input  erx_pkg::emesh_packet_t cfg_packet,
   input  logic                   rxwr_wait,
   input  logic                   rxrd_wait,
   input  logic                   rxrr_wait,
   output logic                   stall,
   output logic                   cfg_wait,
   output logic                   mbox_access,
   output logic [31:0]            mbox_data,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet
);

   erx_pkg::dest_t         dest;
   logic [2:0]             out_acc;      // Indexed by dest_t
   logic [2:0]             hold_wait;
   logic [2:0]             load;
   erx_pkg::emesh_packet_t out_pkt  [3];
   erx_pkg::emesh_packet_t load_pkt [3];
   logic                   stream_go;    // Stream item moves this cycle
   logic                   cfg_take;

   always_comb begin
      if (!in_packet.write) begin
         dest = erx_pkg::DEST_RD;
      end else if (in_packet.dstaddr[31:20] != erx_pkg::CHIP_ID) begin
         dest = erx_pkg::DEST_WR;  // Foreign page
      end else if (in_packet.dstaddr[19:0] == erx_pkg::MBOX_ADDR) begin
         dest = erx_pkg::DEST_MBOX;
      end else begin
         dest = erx_pkg::DEST_RR;  // Own page write
      end
   end

   assign hold_wait = {rxrr_wait, rxrd_wait, rxwr_wait};
   assign stall     = |(out_acc & hold_wait);  // Any held item blocked
   assign stream_go = in_access & ~stall;
   // Stream has priority on rxrr
   assign cfg_take  = cfg_access & ~(out_acc[erx_pkg::DEST_RR] & rxrr_wait) &
                      ~(stream_go & (dest == erx_pkg::DEST_RR));
   assign cfg_wait  = cfg_access & ~cfg_take;

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         load[i]     = stream_go && (dest == erx_pkg::dest_t'(i));
         load_pkt[i] = in_packet;
      end
      if (cfg_take) begin
         load[erx_pkg::DEST_RR]     = 1'b1;
         load_pkt[erx_pkg::DEST_RR] = cfg_packet;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_acc     <= '0;
         mbox_access <= 1'b0;
         mbox_data   <= '0;
         for (int i = 0; i < 3; i++) begin
            out_pkt[i] <= '0;
         end
      end else begin
         mbox_access <= stream_go && (dest == erx_pkg::DEST_MBOX);  // One cycle strobe
         if (stream_go && (dest == erx_pkg::DEST_MBOX)) begin
            mbox_data <= in_packet.data;
         end
         for (int i = 0; i < 3; i++) begin
            if (load[i]) begin
               out_acc[i] <= 1'b1;
               out_pkt[i] <= load_pkt[i];
            end else if (!hold_wait[i]) begin
               out_acc[i] <= 1'b0;  // Consumed
            end
         end
      end
   end

   assign rxwr_access = out_acc[erx_pkg::DEST_WR];
   assign rxwr_packet = out_pkt[erx_pkg::DEST_WR];
   assign rxrd_access = out_acc[erx_pkg::DEST_RD];
   assign rxrd_packet = out_pkt[erx_pkg::DEST_RD];
   assign rxrr_access = out_acc[erx_pkg::DEST_RR];
   assign rxrr_packet = out_pkt[erx_pkg::DEST_RR];

   // Blocked output holds steady until its wait drops
   for (genvar g = 0; g < 3; g++) begin : g_hold_chk
      a_hold : assert property (@(posedge clk) disable iff (!rst_n)
         out_acc[g] && hold_wait[g] |=> out_acc[g] && $stable(out_pkt[g]));
   end

endmodule

// File: erx_core.sv
`timescale 1ns/1ps

module erx_core (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   rx_access,
   input  logic                   rx_burst,
   input  erx_pkg::emesh_packet_t rx_packet,
   output logic                   rx_wr_wait,
   output logic                   rx_rd_wait,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   input  logic                   rxwr_wait,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   input  logic                   rxrd_wait,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet,
   input  logic                   rxrr_wait,
   input  logic                   erx_cfg_access,
   input  erx_pkg::emesh_packet_t erx_cfg_packet,
   output logic                   erx_cfg_wait,
   output logic [44:0]            idelay_value,
   output logic                   load_taps,
   output logic                   mailbox_irq
);

   logic                   rx_take;        // Packet accepted this cycle
   logic                   stall;
   logic                   prot_access;
   erx_pkg::emesh_packet_t prot_packet;
   logic                   remap_access;
   erx_pkg::emesh_packet_t remap_packet;
   erx_pkg::remap_cfg_t    remap_cfg;
   erx_pkg::mi_bus_t       mi;
   logic [31:0]            cfg_rdata;
   logic [31:0]            mbox_rdata;
   logic                   resp_access;
   erx_pkg::emesh_packet_t resp_packet;
   logic                   resp_wait;
   logic                   mailbox_irq_en;
   logic                   mbox_access;
   logic [31:0]            mbox_data;
   logic                   mbox_overflow;
   logic                   overflow_clr;

   assign rx_wr_wait = stall | rxwr_wait | rxrr_wait;  // Own page writes exit on rxrr
   assign rx_rd_wait = stall | rxrd_wait;
   assign rx_take    = rx_access & ~(rx_packet.write ? rx_wr_wait : rx_rd_wait);

   erx_protocol u_erx_protocol (
      .clk(clk), .rst_n(rst_n), .stall(stall),
      .rx_access(rx_take), .rx_burst(rx_burst), .rx_packet(rx_packet),
      .out_access(prot_access), .out_packet(prot_packet));

   erx_remap u_erx_remap (
      .clk(clk), .rst_n(rst_n), .stall(stall), .remap(remap_cfg),
      .in_access(prot_access), .in_packet(prot_packet),
      .out_access(remap_access), .out_packet(remap_packet));

   erx_arbiter u_erx_arbiter (
      .clk(clk), .rst_n(rst_n),
      .in_access(remap_access), .in_packet(remap_packet),
      .cfg_access(resp_access), .cfg_packet(resp_packet),
      .rxwr_wait(rxwr_wait), .rxrd_wait(rxrd_wait), .rxrr_wait(rxrr_wait),
      .stall(stall), .cfg_wait(resp_wait),
      .mbox_access(mbox_access), .mbox_data(mbox_data),
      .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet),
      .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet),
      .rxrr_access(rxrr_access), .rxrr_packet(rxrr_packet));

   erx_cfgif u_erx_cfgif (
      .clk(clk), .rst_n(rst_n),
      .cfg_access_in(erx_cfg_access), .cfg_packet_in(erx_cfg_packet),
      .mi(mi), .cfg_rdata(cfg_rdata), .mbox_rdata(mbox_rdata),
      .resp_access(resp_access), .resp_packet(resp_packet),
      .resp_wait(resp_wait), .cfg_wait(erx_cfg_wait));

   erx_cfg u_erx_cfg (
      .clk(clk), .rst_n(rst_n), .mi(mi), .rdata(cfg_rdata),
      .status_in({rx_rd_wait, rx_wr_wait, rxrr_wait, rxrd_wait, rxwr_wait}),
      .mbox_overflow(mbox_overflow), .overflow_clr(overflow_clr),
      .remap(remap_cfg), .mailbox_irq_en(mailbox_irq_en),
      .idelay_value(idelay_value), .load_taps(load_taps));

   erx_mailbox u_erx_mailbox (
      .clk(clk), .rst_n(rst_n),
      .mbox_access(mbox_access), .mbox_data(mbox_data),
      .mi(mi), .rdata(mbox_rdata), .irq_en(mailbox_irq_en),
      .overflow(mbox_overflow), .overflow_clr(overflow_clr),
      .mailbox_irq(mailbox_irq));

endmodule

// File: erx_core_tb.sv
`timescale 1ns/1ps

module erx_core_tb;

   localparam int TIMEOUT_CYCLES = 4000;  // All tests take well under 1000 cycles

   typedef struct packed {
      erx_pkg::emesh_packet_t pkt;
      logic [31:0]            due;   // Expected output cycle, 0 when untimed
   } expect_t;

   logic                   clk;
   logic                   rst_n;
   logic                   rx_access;
   logic                   rx_burst;
   erx_pkg::emesh_packet_t rx_packet;
   logic                   rx_wr_wait;
   logic                   rx_rd_wait;
   logic [2:0]             out_acc;        // rxwr, rxrd, rxrr
   logic [2:0]             out_wait;
   erx_pkg::emesh_packet_t out_pkt [3];
   logic                   erx_cfg_access;
   erx_pkg::emesh_packet_t erx_cfg_packet;
   logic                   erx_cfg_wait;
   logic [44:0]            idelay_value;
   logic                   load_taps;
   logic                   mailbox_irq;

   logic [31:0]            cyc;
   logic [31:0]            lfsr;
   string                  test_name;
   expect_t                q_out [3][$];   // Model queue per output
   logic [31:0]            q_mbox [$];     // Mailbox contents
   expect_t                exp_head [3];
   logic [2:0]             head_ok;
   logic                   timed;          // Check exact latency
   logic [31:0]            last_dst;       // Burst base
   erx_pkg::remap_mode_t   m_mode;
   logic [11:0]            m_sel;
   logic [11:0]            m_pat;
   logic [31:0]            m_base;
   logic                   m_irq_en;
   logic                   m_ovf;
   logic [44:0]            m_idelay;
   logic [31:0]            tap_due;
   int                     taps_seen;

   erx_core u_erx_core (
      .clk(clk), .rst_n(rst_n),
      .rx_access(rx_access), .rx_burst(rx_burst), .rx_packet(rx_packet),
      .rx_wr_wait(rx_wr_wait), .rx_rd_wait(rx_rd_wait),
      .rxwr_access(out_acc[0]), .rxwr_packet(out_pkt[0]), .rxwr_wait(out_wait[0]),
      .rxrd_access(out_acc[1]), .rxrd_packet(out_pkt[1]), .rxrd_wait(out_wait[1]),
      .rxrr_access(out_acc[2]), .rxrr_packet(out_pkt[2]), .rxrr_wait(out_wait[2]),
      .erx_cfg_access(erx_cfg_access), .erx_cfg_packet(erx_cfg_packet),
      .erx_cfg_wait(erx_cfg_wait), .idelay_value(idelay_value),
      .load_taps(load_taps), .mailbox_irq(mailbox_irq));

   always #5 clk = ~clk;

   // Head of each queue, settled before the next rising edge
   always @(negedge clk) begin
      for (int i = 0; i < 3; i++) begin
         exp_head[i] = (q_out[i].size() != 0) ? q_out[i][0] : '0;
         head_ok[i]  = (q_out[i].size() != 0) && (out_pkt[i] == exp_head[i].pkt) &&
                       (exp_head[i].due == 0 || exp_head[i].due == cyc);
      end
   end

   for (genvar g = 0; g < 3; g++) begin : g_out_chk
      a_out : assert property (@(posedge clk) disable iff (!rst_n) out_acc[g] |-> head_ok[g])
         else report_error($sformatf("error %s %s expected %h due %0d actual %h cycle %0d",
            test_name, (g == 0) ? "rxwr" : (g == 1) ? "rxrd" : "rxrr",
            exp_head[g].pkt, exp_head[g].due, $sampled(out_pkt[g]), $sampled(cyc)));
   end

   a_taps : assert property (@(posedge clk) disable iff (!rst_n) load_taps |-> cyc == tap_due)
      else report_error($sformatf("error %s load_taps expected cycle %0d actual cycle %0d",
         test_name, tap_due, $sampled(cyc)));

   always @(posedge clk) begin
      if (!rst_n) begin
         cyc <= '0;
      end else begin
         cyc <= cyc + 1;
         if (cyc >= TIMEOUT_CYCLES) begin
            report_error("timeout because the run did not finish within the cycle limit");
         end
         for (int i = 0; i < 3; i++) begin
            if (out_acc[i] && !out_wait[i] && q_out[i].size() != 0) begin
               void'(q_out[i].pop_front());  // Consumed by sink
            end
         end
         if (load_taps) begin
            taps_seen <= taps_seen + 1;
         end
      end
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      assert (exp == act)
         else report_error($sformatf("error %s %s expected %h actual %h",
            test_name, what, exp, act));
   endtask

   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Kind 1 read, 2 own page write, 4 mailbox write, else foreign write
   function automatic erx_pkg::emesh_packet_t make_pkt(input logic [2:0] kind);
      erx_pkg::emesh_packet_t p;
      p          = '0;
      p.ctrlmode = rand_bits(5);
      p.datamode = rand_bits(2);
      p.dstaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      p.write    = (kind != 3'd1);
      if (kind == 3'd2 || kind == 3'd4) begin
         p.dstaddr[31:20] = erx_pkg::CHIP_ID;
         if (p.dstaddr[19:0] == erx_pkg::MBOX_ADDR) begin
            p.dstaddr[0] = ~p.dstaddr[0];  // Not the mailbox
         end
      end else if (p.dstaddr[31:20] == erx_pkg::CHIP_ID) begin
         p.dstaddr[31] = ~p.dstaddr[31];   // Off own page
      end
      if (kind == 3'd4) begin
         p.dstaddr[19:0] = erx_pkg::MBOX_ADDR;
      end
      return p;
   endfunction

   function automatic logic [31:0] remap_addr(input logic [31:0] a);
      logic [31:0] r;
      r = a;
      case (m_mode)
         erx_pkg::REMAP_STATIC: begin
            for (int b = 0; b < 12; b++) begin
               if (m_sel[b]) begin
                  r[20 + b] = m_pat[b];  // Selected page bit from pattern
               end
            end
         end
         erx_pkg::REMAP_DYNAMIC: r = a + m_base;
         default: ;
      endcase
      return r;
   endfunction

   function automatic erx_pkg::dest_t route(input erx_pkg::emesh_packet_t p);
      if (!p.write) return erx_pkg::DEST_RD;
      if (p.dstaddr[31:20] != erx_pkg::CHIP_ID) return erx_pkg::DEST_WR;
      if (p.dstaddr[19:0] == erx_pkg::MBOX_ADDR) return erx_pkg::DEST_MBOX;
      return erx_pkg::DEST_RR;
   endfunction

   task automatic send_rx(input erx_pkg::emesh_packet_t p, input logic burst);
      expect_t        e;
      erx_pkg::dest_t dest;
      rx_packet = p;
      rx_burst  = burst;
      rx_access = 1'b1;
      #1;
      while (p.write ? rx_wr_wait : rx_rd_wait) begin
         @(negedge clk);
         #1;
      end
      if (burst) begin
         p.dstaddr = last_dst + erx_pkg::BURST_STRIDE;
      end
      last_dst  = p.dstaddr;
      p.dstaddr = remap_addr(p.dstaddr);
      dest      = route(p);
      if (dest == erx_pkg::DEST_MBOX) begin
         if (q_mbox.size() < erx_pkg::MBOX_DEPTH) begin
            q_mbox.push_back(p.data);
         end else begin
            m_ovf = 1'b1;  // Dropped when full
         end
      end else begin
         e.pkt = p;
         e.due = timed ? cyc + 32'd3 : 32'd0;
         q_out[int'(dest)].push_back(e);
      end
      @(negedge clk);
      rx_access = 1'b0;
      rx_burst  = 1'b0;
   endtask

   // Returns once the request is sure to be taken at the next rising edge
   task automatic cfg_accept(input erx_pkg::emesh_packet_t p, output logic [31:0] k);
      erx_cfg_packet = p;
      erx_cfg_access = 1'b1;
      #1;
      while (erx_cfg_wait) begin
         @(negedge clk);
         #1;
      end
      k = cyc;
   endtask

   task automatic cfg_write(input erx_pkg::reg_addr_t r, input logic [31:0] d);
      erx_pkg::emesh_packet_t p;
      logic [31:0]            k;
      p         = '0;
      p.write   = 1'b1;
      p.dstaddr = {erx_pkg::CHIP_ID, 14'b0, r, 2'b00};
      p.data    = d;
      cfg_accept(p, k);
      case (r)
         erx_pkg::REG_RXCFG: begin
            m_mode   = erx_pkg::remap_mode_t'(d[1:0]);
            m_sel    = d[13:2];
            m_pat    = d[25:14];
            m_irq_en = d[26];
         end
         erx_pkg::REG_RXOFFSET:  m_base         = d;
         erx_pkg::REG_RXIDELAY0: m_idelay[31:0] = d;
         erx_pkg::REG_RXIDELAY1: begin
            m_idelay[44:32] = d[12:0];
            tap_due         = k + 32'd2;
         end
         default: ;
      endcase
      @(negedge clk);
      erx_cfg_access = 1'b0;
   endtask

   task automatic cfg_read(input erx_pkg::reg_addr_t r, input logic [31:0] exp_data);
      erx_pkg::emesh_packet_t p;
      expect_t                e;
      logic [31:0]            k;
      p         = '0;
      p.dstaddr = {erx_pkg::CHIP_ID, 14'b0, r, 2'b00};
      p.srcaddr = rand_bits(32);
      cfg_accept(p, k);
      e             = '0;
      e.pkt.write   = 1'b1;
      e.pkt.dstaddr = p.srcaddr;  // Addresses swapped
      e.pkt.srcaddr = p.dstaddr;
      e.pkt.data    = exp_data;
      e.due         = k + 32'd2;
      q_out[2].push_back(e);
      @(negedge clk);
      erx_cfg_access = 1'b0;
   endtask

   task automatic read_mailbox();
      logic [31:0] d;
      d = 32'h0;  // Empty FIFO reads zero
      if (q_mbox.size() != 0) begin
         d = q_mbox.pop_front();
      end
      cfg_read(erx_pkg::REG_RXMAILBOX, d);
   endtask

   task automatic wait_idle();
      while (q_out[0].size() + q_out[1].size() + q_out[2].size() != 0) begin
         @(negedge clk);
      end
      repeat (5) @(negedge clk);  // Mailbox push trails the output stage
   endtask

   initial begin
      erx_pkg::emesh_packet_t fp;
      logic [31:0]            val;
      logic [31:0]            k;
      clk            = 1'b0;
      rst_n          = 1'b0;
      rx_access      = 1'b0;
      rx_burst       = 1'b0;
      rx_packet      = '0;
      out_wait       = '0;
      erx_cfg_access = 1'b0;
      erx_cfg_packet = '0;
      lfsr           = 32'he009c6e5;
      timed          = 1'b1;
      last_dst       = '0;
      m_mode         = erx_pkg::REMAP_NONE;
      m_sel          = '0;
      m_pat          = '0;
      m_base         = '0;
      m_irq_en       = 1'b0;
      m_ovf          = 1'b0;
      m_idelay       = '0;
      tap_due        = '0;
      taps_seen      = 0;
      test_name      = "reset";
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      test_name = "routing";
      for (int i = 0; i < 16; i++) send_rx(make_pkt(rand_bits(2)), 1'b0);
      wait_idle();

      test_name = "remap static";
      val = rand_bits(24);
      cfg_write(erx_pkg::REG_RXCFG, {6'b0, val[23:0], 2'd1});
      for (int i = 0; i < 8; i++) send_rx(make_pkt(rand_bits(2)), 1'b0);
      wait_idle();
      test_name = "remap dynamic";
      cfg_write(erx_pkg::REG_RXOFFSET, rand_bits(32));
      cfg_write(erx_pkg::REG_RXCFG, 32'd2);
      for (int i = 0; i < 8; i++) send_rx(make_pkt(rand_bits(2)), 1'b0);
      wait_idle();
      cfg_write(erx_pkg::REG_RXCFG, 32'd0);

      test_name = "burst";
      send_rx(make_pkt(0), 1'b0);
      for (int i = 0; i < 6; i++) send_rx(make_pkt(0), 1'b1);
      wait_idle();

      test_name = "config";
      val = rand_bits(32);
      cfg_write(erx_pkg::REG_RXOFFSET, val);
      cfg_read(erx_pkg::REG_RXOFFSET, val);
      val = rand_bits(27) & 32'h07ff_fffc;  // Remap stays off
      cfg_write(erx_pkg::REG_RXCFG, val);
      cfg_read(erx_pkg::REG_RXCFG, val);
      val = rand_bits(32);
      cfg_write(erx_pkg::REG_RXIDELAY0, val);
      cfg_read(erx_pkg::REG_RXIDELAY0, val);
      val = rand_bits(32);
      cfg_write(erx_pkg::REG_RXIDELAY1, val);
      cfg_read(erx_pkg::REG_RXIDELAY1, {19'b0, val[12:0]});
      wait_idle();
      check_value("idelay_value", m_idelay, idelay_value);
      check_value("load_taps pulses", 1, taps_seen);
      test_name = "config foreign id";
      fp                = make_pkt(1);  // Read for another chip, no response
      cfg_accept(fp, k);
      @(negedge clk);
      erx_cfg_access = 1'b0;
      wait_idle();

      test_name = "mailbox";
      cfg_write(erx_pkg::REG_RXCFG, 32'h0400_0000);
      for (int i = 0; i < 3; i++) send_rx(make_pkt(4), 1'b0);
      wait_idle();
      check_value("mailbox_irq", m_irq_en && (q_mbox.size() != 0), mailbox_irq);
      while (q_mbox.size() != 0) read_mailbox();
      wait_idle();
      check_value("mailbox_irq", 0, mailbox_irq);
      test_name = "mailbox overflow";
      for (int i = 0; i < 9; i++) send_rx(make_pkt(4), 1'b0);
      wait_idle();
      cfg_read(erx_pkg::REG_RXSTATUS, {26'b0, m_ovf, 5'b0});
      m_ovf = 1'b0;  // Cleared by the status read
      cfg_read(erx_pkg::REG_RXSTATUS, {26'b0, m_ovf, 5'b0});
      while (q_mbox.size() != 0) read_mailbox();
      read_mailbox();
      wait_idle();
      check_value("mailbox_irq", 0, mailbox_irq);

      test_name = "back-pressure";
      timed     = 1'b0;
      for (int i = 0; i < 4; i++) send_rx(make_pkt(0), 1'b0);
      out_wait[0] = 1'b1;
      fork
         begin
            repeat (12) @(negedge clk);
            out_wait[0] = 1'b0;  // Sink ready again
         end
      join_none
      @(negedge clk);
      check_value("rx_wr_wait", 1, rx_wr_wait);
      check_value("rx_rd_wait", 1, rx_rd_wait);  // Held rxwr stalls reads too
      for (int i = 0; i < 6; i++) send_rx(make_pkt(0), 1'b0);
      wait_idle();
      timed = 1'b1;

      if (q_out[0].size() + q_out[1].size() + q_out[2].size() == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         report_error("packets were still expected at the end of the run");
      end
   end

endmodule

// File: sources.f
erx_pkg.sv
erx_protocol.sv
erx_remap.sv
erx_cfg.sv
erx_cfgif.sv
erx_mailbox.sv
erx_arbiter.sv
erx_core.sv
erx_core_tb.sv
